// File: src/spi_filter_pkg.sv
//////////////////////////////////////////////////////////////////////
// spi flash command filter shared definitions
// opcodes, command classes and the widths shared by every block
//////////////////////////////////////////////////////////////////////
package spi_filter_pkg;

    typedef logic [7:0] spi_byte_t;     // one byte shifted in on mosi
    typedef logic [7:0] opcode_t;       // first byte of every transaction

    //////////////////////////////////////////////////////////////////////
    // opcodes the filter recognizes, anything not listed here is illegal
    //////////////////////////////////////////////////////////////////////
    localparam opcode_t OP_READ          = 8'h03;
    localparam opcode_t OP_FAST_READ     = 8'h0B;
    localparam opcode_t OP_READ_STATUS   = 8'h05;
    localparam opcode_t OP_READ_ID       = 8'h9F;
    localparam opcode_t OP_WRITE_ENABLE  = 8'h06;
    localparam opcode_t OP_WRITE_DISABLE = 8'h04;
    localparam opcode_t OP_PAGE_PROGRAM  = 8'h02;   // needs the block check
    localparam opcode_t OP_SECTOR_ERASE  = 8'h20;   // needs the block check

    // how the decoder treats an opcode once it has been shifted in
    typedef enum logic [1:0] {
        CMD_ALLOWED,
        CMD_ADDR_CHECKED,
        CMD_ILLEGAL
    } cmd_class_t;

    // byte address bits that fall inside one 4 kB block
    localparam int BLOCK_OFFSET_BITS = 12;

    // mask word on the register port, bit n of word w enables block w*32+n
    localparam int WE_WORD_BITS = 32;
    typedef logic [WE_WORD_BITS-1:0] we_word_t;

    typedef logic [4:0] filter_count_t;     // saturates at 31

    localparam int ADDR_BYTES = 3;          // 3-byte addressing only

endpackage

// File: src/spi_bit_sampler.sv
//////////////////////////////////////////////////////////////////////
// spi bit sampler
// oversamples the monitored spi pins in the system clock domain and
// turns mosi bits into one strobe per received byte
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module spi_bit_sampler (
    input  logic                      sys_clock,
    input  logic                      i_sys_resetn,
    input  logic                      i_spi_sclk,       // host serial clock, asynchronous
    input  logic                      i_spi_mosi,
    input  logic                      i_spi_csn,        // host chip select, active low
    output logic                      o_cs_active,      // synchronized chip select is low
    output logic                      o_byte_valid,     // one cycle per completed byte
    output spi_filter_pkg::spi_byte_t o_byte
);
    import spi_filter_pkg::*;

    logic [1:0] sclk_sync;      // bit 1 is the synchronized copy
    logic [1:0] mosi_sync;
    logic [1:0] csn_sync;
    logic       sclk_prev;      // edge detect register
    logic       sclk_rise;
    logic [2:0] bit_cnt;
    spi_byte_t  shift_q;

    always_ff @(posedge sys_clock or negedge i_sys_resetn) begin
        if (!i_sys_resetn) begin
            sclk_sync <= '0;
            mosi_sync <= '0;
            csn_sync  <= '1;            // bus idles deselected
            sclk_prev <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], i_spi_sclk};
            mosi_sync <= {mosi_sync[0], i_spi_mosi};
            csn_sync  <= {csn_sync[0], i_spi_csn};
            sclk_prev <= sclk_sync[1];
        end
    end

    // only edges inside an active chip select carry data
    assign sclk_rise = sclk_sync[1] & ~sclk_prev & ~csn_sync[1];

    always_ff @(posedge sys_clock or negedge i_sys_resetn) begin
        if (!i_sys_resetn) begin
            o_cs_active  <= 1'b0;
            o_byte_valid <= 1'b0;
            bit_cnt      <= '0;
        end else begin
            o_cs_active  <= ~csn_sync[1];                       // aligned with the byte strobe
            o_byte_valid <= sclk_rise & (bit_cnt == 3'd7);      // eighth bit closes the byte
            if (csn_sync[1]) begin
                bit_cnt <= '0;                                  // next transaction starts on bit 0
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
            end
        end
    end

    // mosi arrives msb first
    always_ff @(posedge sys_clock) begin
        if (sclk_rise) begin
            shift_q <= {shift_q[6:0], mosi_sync[1]};
        end
    end

    assign o_byte = shift_q;    // holds the full byte in the strobe cycle

    // every byte strobe follows eight sclk edges inside one active chip select
    a_byte_in_cs: assert property (@(posedge sys_clock) disable iff (!i_sys_resetn)
        o_byte_valid |-> o_cs_active && $past(o_cs_active, 8));

endmodule

// File: src/spi_command_decoder.sv
//////////////////////////////////////////////////////////////////////
// spi command decoder
// classifies the opcode of each transaction, collects the address of
// program and erase commands and decides whether to cut the chip select
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module spi_command_decoder #(
    parameter int FLASH_ADDRESS_BITS = 24                   // 24 bits is 16 MB
) (
    input  logic                      sys_clock,
    input  logic                      i_sys_resetn,
    input  logic                      i_cs_active,
    input  logic                      i_byte_valid,
    input  spi_filter_pkg::spi_byte_t i_byte,
    input  logic                      i_filter_disable,     // permissive mode
    input  logic                      i_block_enabled,      // mask bit for o_block_index
    output logic [FLASH_ADDRESS_BITS-spi_filter_pkg::BLOCK_OFFSET_BITS-1:0] o_block_index,
    output logic                      o_cs_block,           // held until the chip select drops
    output logic                      o_block_event,        // first cycle of o_cs_block
    output spi_filter_pkg::opcode_t   o_block_opcode
);
    import spi_filter_pkg::*;

    localparam int ADDR_BITS  = ADDR_BYTES * 8;
    localparam int SHIFT_BITS = ADDR_BITS - 8;              // address bytes held before the last

    typedef enum logic [1:0] {
        ST_IDLE,        // chip select inactive
        ST_OPCODE,      // waiting for the first byte
        ST_ADDRESS,     // collecting the address of a checked command
        ST_PASS         // decision made, ride out the transaction
    } state_t;

    state_t                state;
    logic [1:0]            addr_cnt;
    logic [SHIFT_BITS-1:0] addr_q;
    logic [ADDR_BITS-1:0]  addr_next;
    opcode_t               opcode_q;
    cmd_class_t            op_class;
    logic                  block_now;

    function automatic cmd_class_t classify(input opcode_t op);
        case (op)
            OP_READ, OP_FAST_READ, OP_READ_STATUS, OP_READ_ID,
            OP_WRITE_ENABLE, OP_WRITE_DISABLE: classify = CMD_ALLOWED;
            OP_PAGE_PROGRAM, OP_SECTOR_ERASE:  classify = CMD_ADDR_CHECKED;
            default:                           classify = CMD_ILLEGAL;
        endcase
    endfunction

    assign op_class  = classify(i_byte);
    assign addr_next = {addr_q, i_byte};    // complete address while the last byte is valid

    // the mask memory answers in the same cycle, so the last address byte decides at once
    assign o_block_index  = addr_next[FLASH_ADDRESS_BITS-1:BLOCK_OFFSET_BITS];
    assign o_block_opcode = opcode_q;

    //////////////////////////////////////////////////////////////////////
    // blocking decision
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        block_now = 1'b0;
        if (i_byte_valid && !i_filter_disable) begin
            if (state == ST_OPCODE) begin
                block_now = (op_class == CMD_ILLEGAL);
            end else if (state == ST_ADDRESS && addr_cnt == 2'(ADDR_BYTES - 1)) begin
                block_now = !i_block_enabled;       // program or erase into a protected block
            end
        end
    end

    always_ff @(posedge sys_clock or negedge i_sys_resetn) begin
        if (!i_sys_resetn) begin
            state         <= ST_IDLE;
            addr_cnt      <= '0;
            o_cs_block    <= 1'b0;
            o_block_event <= 1'b0;
        end else if (!i_cs_active) begin
            state         <= ST_IDLE;               // every transaction starts fresh
            addr_cnt      <= '0;
            o_cs_block    <= 1'b0;
            o_block_event <= 1'b0;
        end else begin
            o_block_event <= block_now;
            if (block_now) begin
                o_cs_block <= 1'b1;
            end
            case (state)
                ST_IDLE: state <= ST_OPCODE;
                ST_OPCODE: begin
                    if (i_byte_valid) begin
                        addr_cnt <= '0;
                        state    <= (op_class == CMD_ADDR_CHECKED) ? ST_ADDRESS : ST_PASS;
                    end
                end
                ST_ADDRESS: begin
                    if (i_byte_valid) begin
                        addr_cnt <= addr_cnt + 2'd1;
                        if (addr_cnt == 2'(ADDR_BYTES - 1)) begin
                            state <= ST_PASS;
                        end
                    end
                end
                default: state <= ST_PASS;          // data bytes are not inspected
            endcase
        end
    end

    // opcode and leading address bytes
    always_ff @(posedge sys_clock) begin
        if (i_byte_valid && state == ST_OPCODE) begin
            opcode_q <= i_byte;
        end
        if (i_byte_valid && state == ST_ADDRESS) begin
            addr_q <= addr_next[SHIFT_BITS-1:0];
        end
    end

    // the output stage counts one event per blocked transaction
    a_event_on_rise: assert property (@(posedge sys_clock) disable iff (!i_sys_resetn)
        o_block_event |-> o_cs_block && !$past(o_cs_block));

endmodule

// File: src/we_mask_memory.sv
//////////////////////////////////////////////////////////////////////
// write-enable mask memory
// one enable bit per 4 kB flash block, written and read back as 32-bit
// words on the register port and looked up bit by bit for the decoder
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module we_mask_memory #(
    parameter int FLASH_ADDRESS_BITS = 24
) (
    input  logic                            sys_clock,
    input  logic                            i_sys_resetn,
    input  logic                            i_we_write,
    input  logic [FLASH_ADDRESS_BITS-18:0]  i_we_address,       // 128 words at 16 MB
    input  spi_filter_pkg::we_word_t        i_we_writedata,
    input  logic                            i_we_read,
    input  logic [FLASH_ADDRESS_BITS-spi_filter_pkg::BLOCK_OFFSET_BITS-1:0] i_block_index,
    output spi_filter_pkg::we_word_t        o_we_readdata,
    output logic                            o_we_readdatavalid,
    output logic                            o_block_enabled
);
    import spi_filter_pkg::*;

    localparam int BIT_SEL_BITS = $clog2(WE_WORD_BITS);
    localparam int INDEX_BITS   = FLASH_ADDRESS_BITS - BLOCK_OFFSET_BITS;
    localparam int WORDS        = 2 ** (INDEX_BITS - BIT_SEL_BITS);

    we_word_t mask_mem [WORDS];
    we_word_t lookup_word;

    // every block starts write protected
    always_ff @(posedge sys_clock or negedge i_sys_resetn) begin
        if (!i_sys_resetn) begin
            for (int w = 0; w < WORDS; w++) begin
                mask_mem[w] <= '0;
            end
            o_we_readdatavalid <= 1'b0;
        end else begin
            o_we_readdatavalid <= i_we_read;                    // fixed one cycle read latency
            if (i_we_write) begin
                mask_mem[i_we_address] <= i_we_writedata;       // whole word replaced
            end
        end
    end

    always_ff @(posedge sys_clock) begin
        if (i_we_read) begin
            o_we_readdata <= mask_mem[i_we_address];
        end
    end

    // upper index bits pick the word, the low five the bit inside it
    assign lookup_word     = mask_mem[i_block_index[INDEX_BITS-1:BIT_SEL_BITS]];
    assign o_block_enabled = lookup_word[i_block_index[BIT_SEL_BITS-1:0]];

    a_no_rw_collision: assert property (@(posedge sys_clock) disable iff (!i_sys_resetn)
        !(i_we_write && i_we_read));

endmodule

// File: src/cs_output_stage.sv
//////////////////////////////////////////////////////////////////////
// chip select output stage
// picks the flash chip select from the internal master or the filtered
// host and keeps the filter status
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module cs_output_stage (
    input  logic                          sys_clock,
    input  logic                          i_sys_resetn,
    input  logic                          i_spi_csn,          // host chip select straight from the pin
    input  logic                          i_cs_block,
    input  logic                          i_block_event,
    input  spi_filter_pkg::opcode_t       i_block_opcode,
    input  logic                          i_master_sel,       // internal master owns the flash
    input  logic                          i_master_csn,
    output logic                          o_spi_csn,
    output spi_filter_pkg::filter_count_t o_filtered_count,
    output spi_filter_pkg::opcode_t       o_last_filtered_opcode
);
    import spi_filter_pkg::*;

    localparam filter_count_t COUNT_MAX = '1;

    // the host pin is used unsynchronized so a deselect reaches the flash at once
    assign o_spi_csn = i_master_sel ? i_master_csn : (i_spi_csn | i_cs_block);

    //////////////////////////////////////////////////////////////////////
    // filter status
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge sys_clock or negedge i_sys_resetn) begin
        if (!i_sys_resetn) begin
            o_filtered_count       <= '0;
            o_last_filtered_opcode <= '0;
        end else if (i_block_event) begin
            o_last_filtered_opcode <= i_block_opcode;
            if (o_filtered_count != COUNT_MAX) begin
                o_filtered_count <= o_filtered_count + 1'b1;    // sticks at 31
            end
        end
    end

endmodule

// File: src/spi_filter_top.sv
//////////////////////////////////////////////////////////////////////
// spi flash command filter
// monitors host spi traffic and deselects the flash for illegal or
// write protected commands
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module spi_filter_top #(
    parameter int FLASH_ADDRESS_BITS = 24
) (
    input  logic                            sys_clock,
    input  logic                            i_sys_resetn,
    // monitored host spi pins
    input  logic                            i_spi_sclk,
    input  logic                            i_spi_mosi,
    input  logic                            i_spi_csn,
    // control
    input  logic                            i_filter_disable,
    input  logic                            i_master_sel,
    input  logic                            i_master_csn,
    // mask register port
    input  logic                            i_we_write,
    input  logic [FLASH_ADDRESS_BITS-18:0]  i_we_address,
    input  spi_filter_pkg::we_word_t        i_we_writedata,
    input  logic                            i_we_read,
    output spi_filter_pkg::we_word_t        o_we_readdata,
    output logic                            o_we_readdatavalid,
    // flash side and status
    output logic                            o_spi_csn,
    output spi_filter_pkg::filter_count_t   o_filtered_count,
    output spi_filter_pkg::opcode_t         o_last_filtered_opcode
);
    import spi_filter_pkg::*;

    logic                                        cs_active;
    logic                                        byte_valid;
    spi_byte_t                                   rx_byte;
    logic [FLASH_ADDRESS_BITS-BLOCK_OFFSET_BITS-1:0] block_index;
    logic                                        block_enabled;
    logic                                        cs_block;
    logic                                        block_event;
    opcode_t                                     block_opcode;

    spi_bit_sampler u_sampler (
        .sys_clock      (sys_clock),
        .i_sys_resetn   (i_sys_resetn),
        .i_spi_sclk     (i_spi_sclk),
        .i_spi_mosi     (i_spi_mosi),
        .i_spi_csn      (i_spi_csn),
        .o_cs_active    (cs_active),
        .o_byte_valid   (byte_valid),
        .o_byte         (rx_byte)
    );

    spi_command_decoder #(
        .FLASH_ADDRESS_BITS (FLASH_ADDRESS_BITS)
    ) u_decoder (
        .sys_clock          (sys_clock),
        .i_sys_resetn       (i_sys_resetn),
        .i_cs_active        (cs_active),
        .i_byte_valid       (byte_valid),
        .i_byte             (rx_byte),
        .i_filter_disable   (i_filter_disable),
        .i_block_enabled    (block_enabled),
        .o_block_index      (block_index),
        .o_cs_block         (cs_block),
        .o_block_event      (block_event),
        .o_block_opcode     (block_opcode)
    );

    we_mask_memory #(
        .FLASH_ADDRESS_BITS (FLASH_ADDRESS_BITS)
    ) u_mask (
        .sys_clock          (sys_clock),
        .i_sys_resetn       (i_sys_resetn),
        .i_we_write         (i_we_write),
        .i_we_address       (i_we_address),
        .i_we_writedata     (i_we_writedata),
        .i_we_read          (i_we_read),
        .i_block_index      (block_index),
        .o_we_readdata      (o_we_readdata),
        .o_we_readdatavalid (o_we_readdatavalid),
        .o_block_enabled    (block_enabled)
    );

    cs_output_stage u_cs_out (
        .sys_clock              (sys_clock),
        .i_sys_resetn           (i_sys_resetn),
        .i_spi_csn              (i_spi_csn),
        .i_cs_block             (cs_block),
        .i_block_event          (block_event),
        .i_block_opcode         (block_opcode),
        .i_master_sel           (i_master_sel),
        .i_master_csn           (i_master_csn),
        .o_spi_csn              (o_spi_csn),
        .o_filtered_count       (o_filtered_count),
        .o_last_filtered_opcode (o_last_filtered_opcode)
    );

endmodule

// File: dv/tb_clock_gen.sv
//////////////////////////////////////////////////////////////////////
// testbench clock and reset generator
// free running system clock and an active low reset held a few cycles
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic o_sys_clock,
    output logic o_sys_resetn
);
    initial begin
        o_sys_clock = 1'b0;
        forever #(PERIOD_NS / 2) o_sys_clock = ~o_sys_clock;
    end

    initial begin
        o_sys_resetn = 1'b0;                            // reset asserted from time zero
        repeat (RESET_CYCLES) @(posedge o_sys_clock);
        o_sys_resetn <= 1'b1;                           // released on a rising edge
    end

endmodule

// File: dv/spi_filter_tb.sv
//////////////////////////////////////////////////////////////////////
// spi flash command filter testbench
// drives host spi transactions and the mask register port through
// directed tests and checks the flash chip select and filter status
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module spi_filter_tb;
    import spi_filter_pkg::*;

    localparam int FLASH_ADDRESS_BITS = 24;
    localparam int SCLK_HALF_CYCLES   = 4;      // sys_clock cycles per sclk phase
    localparam int WATCHDOG_NS = 12 * 6 * 8 * 2 * SCLK_HALF_CYCLES * 10 * 2;
    localparam logic [23:0] ERASE_ADDR   = 24'h123456;     // block 123h, word 9 bit 3
    localparam logic [23:0] PROGRAM_ADDR = 24'h124100;     // the next block up
    localparam opcode_t     OP_ILLEGAL   = 8'hC7;          // chip erase, never allowed

    logic                           sys_clock;
    logic                           sys_resetn;
    logic                           spi_sclk;
    logic                           spi_mosi;
    logic                           spi_csn;
    logic                           filter_disable;
    logic                           master_sel;
    logic                           master_csn;
    logic                           we_write;
    logic [FLASH_ADDRESS_BITS-18:0] we_address;
    we_word_t                       we_writedata;
    logic                           we_read;
    we_word_t                       we_readdata;
    logic                           we_readdatavalid;
    logic                           flash_csn;
    filter_count_t                  filtered_count;
    opcode_t                        last_opcode;

    integer        seed;
    int            errors;
    filter_count_t exp_count;       // running model of the filtered count
    logic          cs_cut_seen;     // flash deselected while the host held it selected

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(5)) u_clock_gen (
        .o_sys_clock  (sys_clock),
        .o_sys_resetn (sys_resetn)
    );

    spi_filter_top #(.FLASH_ADDRESS_BITS(FLASH_ADDRESS_BITS)) UUT (
        .sys_clock              (sys_clock),
        .i_sys_resetn           (sys_resetn),
        .i_spi_sclk             (spi_sclk),
        .i_spi_mosi             (spi_mosi),
        .i_spi_csn              (spi_csn),
        .i_filter_disable       (filter_disable),
        .i_master_sel           (master_sel),
        .i_master_csn           (master_csn),
        .i_we_write             (we_write),
        .i_we_address           (we_address),
        .i_we_writedata         (we_writedata),
        .i_we_read              (we_read),
        .o_we_readdata          (we_readdata),
        .o_we_readdatavalid     (we_readdatavalid),
        .o_spi_csn              (flash_csn),
        .o_filtered_count       (filtered_count),
        .o_last_filtered_opcode (last_opcode)
    );

    //////////////////////////////////////////////////////////////////////
    // compare tasks, one per kind of result
    //////////////////////////////////////////////////////////////////////
    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_opcode(input string name, input opcode_t expected, input opcode_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input filter_count_t expected,
                               input filter_count_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_word(input string name, input we_word_t expected, input we_word_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // sampled on the falling edge where everything driven at the rising edge has settled
    always @(negedge sys_clock) begin
        if (!spi_csn && flash_csn) begin
            cs_cut_seen = 1'b1;
        end
        if (master_sel) begin
            check_bit("master_select", master_csn, flash_csn);   // master owns the flash
        end
    end

    //////////////////////////////////////////////////////////////////////
    // spi host driver, mode 0 with msb first
    //////////////////////////////////////////////////////////////////////
    task automatic send_byte(input spi_byte_t value);
        for (int i = 7; i >= 0; i--) begin
            @(posedge sys_clock);
            spi_sclk <= 1'b0;
            spi_mosi <= value[i];                           // data changes while sclk is low
            repeat (SCLK_HALF_CYCLES) @(posedge sys_clock);
            spi_sclk <= 1'b1;
            repeat (SCLK_HALF_CYCLES - 1) @(posedge sys_clock);
        end
    endtask

    task automatic send_transaction(input string name, input opcode_t op, input logic has_addr,
                                    input logic [23:0] addr, input int data_bytes,
                                    output logic cut_seen);
        integer rnd;
        @(posedge sys_clock);
        cs_cut_seen = 1'b0;
        spi_csn  <= 1'b0;
        spi_sclk <= 1'b0;
        send_byte(op);
        if (has_addr) begin
            for (int b = ADDR_BYTES - 1; b >= 0; b--) begin
                send_byte(addr[b*8 +: 8]);
            end
        end
        for (int d = 0; d < data_bytes; d++) begin
            rnd = $random(seed);
            send_byte(rnd[7:0]);
        end
        @(posedge sys_clock);
        spi_sclk <= 1'b0;
        repeat (8) @(posedge sys_clock);                    // room for the deciding byte
        cut_seen = cs_cut_seen;
        spi_csn <= 1'b1;
        @(negedge sys_clock);
        if (!master_sel) begin
            check_bit({name, "_deselect"}, 1'b1, flash_csn);    // host deselect passes at once
        end
        repeat (8) @(posedge sys_clock);                    // idle gap lets the decoder return
    endtask

    //////////////////////////////////////////////////////////////////////
    // mask register port
    //////////////////////////////////////////////////////////////////////
    task automatic write_mask(input logic [FLASH_ADDRESS_BITS-18:0] addr, input we_word_t data);
        @(posedge sys_clock);
        we_write     <= 1'b1;
        we_address   <= addr;
        we_writedata <= data;
        @(posedge sys_clock);
        we_write <= 1'b0;
    endtask

    task automatic read_mask(input logic [FLASH_ADDRESS_BITS-18:0] addr, output we_word_t data);
        int waited;
        data = '0;
        waited = 0;
        @(posedge sys_clock);
        we_read    <= 1'b1;
        we_address <= addr;
        @(posedge sys_clock);
        we_read <= 1'b0;
        @(negedge sys_clock);
        while (!we_readdatavalid && waited < 4) begin
            @(negedge sys_clock);
            waited++;
        end
        if (we_readdatavalid) begin
            data = we_readdata;
        end else begin
            errors++;
            $display("read of mask word %0d never returned a valid strobe", addr);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic test_reset_state();
        @(negedge sys_clock);
        check_count("reset_count", '0, filtered_count);
        check_opcode("reset_last_opcode", 8'h00, last_opcode);
        check_bit("reset_csn_high", 1'b1, flash_csn);
        @(posedge sys_clock);
        spi_csn <= 1'b0;
        @(negedge sys_clock);
        check_bit("reset_csn_low", 1'b0, flash_csn);       // no block before any byte
        @(posedge sys_clock);
        spi_csn <= 1'b1;
        repeat (8) @(posedge sys_clock);
    endtask

    task automatic test_allowed_commands();
        logic cut;
        send_transaction("read", OP_READ, 1'b1, 24'h000100, 2, cut);
        check_bit("read_not_cut", 1'b0, cut);
        send_transaction("read_id", OP_READ_ID, 1'b0, '0, 3, cut);
        check_bit("read_id_not_cut", 1'b0, cut);
        @(negedge sys_clock);
        check_count("allowed_count", exp_count, filtered_count);
    endtask

    task automatic test_illegal_opcode();
        logic cut;
        send_transaction("illegal", OP_ILLEGAL, 1'b0, '0, 1, cut);
        exp_count = exp_count + 5'd1;
        check_bit("illegal_cut", 1'b1, cut);
        @(negedge sys_clock);
        check_count("illegal_count", exp_count, filtered_count);
        check_opcode("illegal_last_opcode", OP_ILLEGAL, last_opcode);
    endtask

    task automatic test_write_enable_mask();
        logic [FLASH_ADDRESS_BITS-13:0] blk;
        logic [FLASH_ADDRESS_BITS-18:0] word_addr;
        we_word_t                       mask_word;
        we_word_t                       read_word;
        logic                           cut;
        blk       = ERASE_ADDR[FLASH_ADDRESS_BITS-1:BLOCK_OFFSET_BITS];
        word_addr = blk[FLASH_ADDRESS_BITS-13:5];          // 32 blocks per mask word
        mask_word = we_word_t'(1) << blk[4:0];
        send_transaction("erase_protected", OP_SECTOR_ERASE, 1'b1, ERASE_ADDR, 0, cut);
        exp_count = exp_count + 5'd1;
        check_bit("erase_protected_cut", 1'b1, cut);
        @(negedge sys_clock);
        check_count("erase_protected_count", exp_count, filtered_count);
        check_opcode("erase_protected_opcode", OP_SECTOR_ERASE, last_opcode);
        write_mask(word_addr, mask_word);
        read_mask(word_addr, read_word);
        check_word("mask_readback", mask_word, read_word);
        send_transaction("erase_enabled", OP_SECTOR_ERASE, 1'b1, ERASE_ADDR, 0, cut);
        check_bit("erase_enabled_cut", 1'b0, cut);
        // neighbor block keeps its clear bit
        send_transaction("program_neighbor", OP_PAGE_PROGRAM, 1'b1, PROGRAM_ADDR, 2, cut);
        exp_count = exp_count + 5'd1;
        check_bit("program_neighbor_cut", 1'b1, cut);
        @(negedge sys_clock);
        check_count("program_neighbor_count", exp_count, filtered_count);
        check_opcode("program_neighbor_opcode", OP_PAGE_PROGRAM, last_opcode);
    endtask

    task automatic test_permissive_mode();
        logic cut;
        @(posedge sys_clock);
        filter_disable <= 1'b1;
        send_transaction("permissive_illegal", OP_ILLEGAL, 1'b0, '0, 1, cut);
        check_bit("permissive_illegal_cut", 1'b0, cut);
        send_transaction("permissive_erase", OP_SECTOR_ERASE, 1'b1, PROGRAM_ADDR, 0, cut);
        check_bit("permissive_erase_cut", 1'b0, cut);
        @(negedge sys_clock);
        check_count("permissive_count", exp_count, filtered_count);
        @(posedge sys_clock);
        filter_disable <= 1'b0;
    endtask

    // the falling edge monitor compares the flash chip select with the master's all along
    task automatic test_master_select();
        logic cut;
        @(posedge sys_clock);
        master_sel <= 1'b1;
        master_csn <= 1'b0;
        send_transaction("master_illegal", OP_ILLEGAL, 1'b0, '0, 1, cut);
        @(posedge sys_clock);
        master_csn <= 1'b1;
        repeat (4) @(posedge sys_clock);
        master_csn <= 1'b0;
        repeat (4) @(posedge sys_clock);
        master_sel <= 1'b0;
        master_csn <= 1'b1;
        repeat (2) @(posedge sys_clock);
    endtask

    initial begin
        seed           = 32'h7a6f3f2a;
        errors         = 0;
        exp_count      = '0;
        cs_cut_seen    = 1'b0;
        spi_sclk       = 1'b0;
        spi_mosi       = 1'b0;
        spi_csn        = 1'b1;      // host idles deselected
        filter_disable = 1'b0;
        master_sel     = 1'b0;
        master_csn     = 1'b1;
        we_write       = 1'b0;
        we_address     = '0;
        we_writedata   = '0;
        we_read        = 1'b0;
        wait (sys_resetn === 1'b1);
        repeat (2) @(posedge sys_clock);
        test_reset_state();
        test_allowed_commands();
        test_illegal_opcode();
        test_write_enable_mask();
        test_permissive_mode();
        test_master_select();
        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // bounds the run at twice the longest expected transaction traffic
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("checks finished with %0d errors", errors + 1);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: spi_filter_top.f
src/spi_filter_pkg.sv
src/spi_bit_sampler.sv
src/spi_command_decoder.sv
src/we_mask_memory.sv
src/cs_output_stage.sv
src/spi_filter_top.sv
dv/tb_clock_gen.sv
dv/spi_filter_tb.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   := spi_filter_top.f
TB_TOP     := spi_filter_tb
RTL_TOP    := spi_filter_top
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := CHECKS FAILED
PASS_MSG   := ALL CHECKS PASSED
LINT_FLAGS := --lint-only --timing -Wall -Wno-fatal
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TB_TOP)
	./$(OBJ_DIR)/$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
